// ==== verilog.f ====
+incdir+.
memtest_pkg.sv
ram_test.sv
ram_ctrl.sv
status_display.sv
memtest_top.sv
tb_mem_model.sv
tb_memtest.sv

// ==== tb_memtest.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the memory self-test with one table row per test
// each row resets the DUT, runs to the end and checks the results
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns
`include "memtest_defs.svh"

module tb_memtest;

  import memtest_pkg::*;

  localparam int NUM_TESTS    = 5;
  localparam int NUM_WORDS    = 1 << `MT_ADDR_W;
  localparam int RESET_CYCLES = 8;
  localparam int CYCLE_LIMIT  = NUM_WORDS * 2 * (`MT_TIMEOUT + 12);

  logic                  clk;
  logic                  reset;
  logic                  clear;
  logic                  stall_en;
  logic                  fault_en;
  logic [`MT_ADDR_W-1:0] fault_addr;
  logic [`MT_BEAT_W-1:0] fault_mask;
  logic                  hang_en;
  logic [`MT_ADDR_W-1:0] hang_addr;
  logic                  mem_en;
  logic                  mem_we;
  logic [`MT_ADDR_W+1:0] mem_addr;
  logic [`MT_BEAT_W-1:0] mem_wdata;
  logic                  mem_ready;
  logic [`MT_BEAT_W-1:0] mem_rdata;
  test_status_t          status;
  logic [6:0]            ssl;

  // test table
  string                 t_name     [0:NUM_TESTS-1];
  logic                  t_stall    [0:NUM_TESTS-1];
  logic                  t_fault    [0:NUM_TESTS-1];
  logic [`MT_ADDR_W-1:0] t_faddr    [0:NUM_TESTS-1];
  logic [`MT_BEAT_W-1:0] t_fmask    [0:NUM_TESTS-1];
  logic                  t_hang     [0:NUM_TESTS-1];
  logic [`MT_ADDR_W-1:0] t_haddr    [0:NUM_TESTS-1];
  logic                  t_error    [0:NUM_TESTS-1];
  logic                  t_tmo      [0:NUM_TESTS-1];
  logic                  t_mismatch [0:NUM_TESTS-1];
  logic [`MT_ADDR_W-1:0] t_fail     [0:NUM_TESTS-1];

  int err_count;
  int pass_count;
  int fail_count;

  memtest_top uut (
    .clk       (clk),
    .reset     (reset),
    .mem_en    (mem_en),
    .mem_we    (mem_we),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_ready (mem_ready),
    .mem_rdata (mem_rdata),
    .status    (status),
    .ssl       (ssl)
  );

  tb_mem_model memory (
    .clk        (clk),
    .clear      (clear),
    .stall_en   (stall_en),
    .fault_en   (fault_en),
    .fault_addr (fault_addr),
    .fault_mask (fault_mask),
    .hang_en    (hang_en),
    .hang_addr  (hang_addr),
    .mem_en     (mem_en),
    .mem_we     (mem_we),
    .mem_addr   (mem_addr),
    .mem_wdata  (mem_wdata),
    .mem_ready  (mem_ready),
    .mem_rdata  (mem_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic set_row(input int r, input string name, input logic stall,
                         input logic fault, input int faddr, input logic [15:0] fmask,
                         input logic hang, input int haddr, input logic e_err,
                         input logic e_tmo, input logic e_mis, input int e_fail);
    t_name[r]     = name;
    t_stall[r]    = stall;
    t_fault[r]    = fault;
    t_faddr[r]    = faddr[`MT_ADDR_W-1:0];
    t_fmask[r]    = fmask;
    t_hang[r]     = hang;
    t_haddr[r]    = haddr[`MT_ADDR_W-1:0];
    t_error[r]    = e_err;
    t_tmo[r]      = e_tmo;
    t_mismatch[r] = e_mis;
    t_fail[r]     = e_fail[`MT_ADDR_W-1:0];
  endtask

  // beat i = ((a << 2) + i) xor A5C3
  function automatic ram_word_u expected_word(input int a);
    ram_word_u w;
    for (int i = 0; i < 4; i++) begin
      w.beat[i] = 16'((a << 2) + i) ^ 16'hA5C3;
    end
    return w;
  endfunction

  task automatic check_status(input string name, input test_status_t exp,
                              input test_status_t act);
    if (act !== exp) begin
      $display("error %s status: expected run=%b end=%b err=%b tmo=%b mis=%b fail=%0d",
               name, exp.running, exp.ended, exp.error, exp.timeout_seen,
               exp.mismatch_seen, exp.fail_addr);
      $display("      actual run=%b end=%b err=%b tmo=%b mis=%b fail=%0d",
               act.running, act.ended, act.error, act.timeout_seen,
               act.mismatch_seen, act.fail_addr);
      err_count++;
    end
  endtask

  task automatic check_word(input string name, input int a, input ram_word_u exp,
                            input ram_word_u act);
    if (act.word !== exp.word) begin
      $display("error %s word %0d: expected %h actual %h", name, a, exp.word, act.word);
      err_count++;
    end
  endtask

  // lamp 0 is the free-running heartbeat
  task automatic check_ssl(input string name, input logic [6:0] exp,
                           input logic [6:0] act);
    if (act[6:1] !== exp[6:1]) begin
      $display("error %s lamps 6..1: expected %b actual %b", name, exp[6:1], act[6:1]);
      err_count++;
    end
  endtask

  task automatic check_flag(input string name, input string what, input logic exp,
                            input logic act);
    if (act !== exp) begin
      $display("error %s %s: expected %b actual %b", name, what, exp, act);
      err_count++;
    end
  endtask

  task automatic run_row(input int r);
    int           cycles;
    int           errs_before;
    logic         hb_prev;
    logic         hb_seen;
    test_status_t exp_st;
    logic [6:0]   exp_ssl;
    ram_word_u    act_w;
    errs_before = err_count;
    @(posedge clk);
    #10;
    reset      = 1'b1;
    clear      = 1'b1;
    stall_en   = t_stall[r];
    fault_en   = t_fault[r];
    fault_addr = t_faddr[r];
    fault_mask = t_fmask[r];
    hang_en    = t_hang[r];
    hang_addr  = t_haddr[r];
    repeat (RESET_CYCLES) begin
      @(posedge clk);
      #10;
    end
    check_flag(t_name[r], "mem_en in reset", 1'b0, mem_en);
    check_flag(t_name[r], "ended in reset", 1'b0, status.ended);
    check_flag(t_name[r], "error in reset", 1'b0, status.error);
    check_flag(t_name[r], "lamp 2 in reset", 1'b1, ssl[2]);
    reset = 1'b0;
    clear = 1'b0;
    @(posedge clk);
    #10;
    check_flag(t_name[r], "running after reset", 1'b1, status.running);
    check_flag(t_name[r], "lamp 1 after reset", 1'b1, ssl[1]);

    cycles  = 0;
    hb_prev = ssl[0];
    hb_seen = 1'b0;
    while (!status.ended && cycles < CYCLE_LIMIT) begin
      @(posedge clk);
      #10;
      cycles++;
      if (ssl[0] !== hb_prev) begin
        hb_seen = 1'b1;
      end
      hb_prev = ssl[0];
    end

    if (!status.ended) begin
      $display("test %s did not end within %0d cycles", t_name[r], CYCLE_LIMIT);
      err_count++;
    end else begin
      exp_st = '{running: 1'b0, ended: 1'b1, error: t_error[r],
                 timeout_seen: t_tmo[r], mismatch_seen: t_mismatch[r],
                 fail_addr: t_fail[r]};
      check_status(t_name[r], exp_st, status);
      exp_ssl = {t_mismatch[r], t_error[r], 1'b1, t_tmo[r], 1'b0, 1'b0, 1'b0};
      check_ssl(t_name[r], exp_ssl, ssl);
      if (!hb_seen) begin
        $display("test %s: heartbeat lamp never toggled", t_name[r]);
        err_count++;
      end
      // a hung word is never written
      for (int a = 0; a < NUM_WORDS; a++) begin
        if (!(t_hang[r] && a == t_haddr[r])) begin
          act_w.beat[0] = memory.ram[4*a];
          act_w.beat[1] = memory.ram[4*a+1];
          act_w.beat[2] = memory.ram[4*a+2];
          act_w.beat[3] = memory.ram[4*a+3];
          check_word(t_name[r], a, expected_word(a), act_w);
        end
      end
    end

    if (err_count == errs_before) begin
      $display("test %s: passed in %0d cycles", t_name[r], cycles);
      pass_count++;
    end else begin
      $display("test %s: failed with %0d errors", t_name[r], err_count - errs_before);
      fail_count++;
    end
  endtask

  initial begin
    reset      = 1'b1;
    clear      = 1'b1;
    stall_en   = 1'b0;
    fault_en   = 1'b0;
    fault_addr = '0;
    fault_mask = '0;
    hang_en    = 1'b0;
    hang_addr  = '0;
    err_count  = 0;
    pass_count = 0;
    fail_count = 0;

    // bit 14 is always low in a pattern beat
    set_row(0, "clean",      1'b0, 1'b0, 0,  16'h0000, 1'b0, 0,  1'b0, 1'b0, 1'b0, 0);
    set_row(1, "stalls",     1'b1, 1'b0, 0,  16'h0000, 1'b0, 0,  1'b0, 1'b0, 1'b0, 0);
    set_row(2, "stuck_even", 1'b0, 1'b1, 18, 16'h4000, 1'b0, 0,  1'b1, 1'b0, 1'b1, 18);
    set_row(3, "stuck_odd",  1'b0, 1'b1, 41, 16'h4000, 1'b0, 0,  1'b1, 1'b0, 1'b1, 41);
    set_row(4, "hang",       1'b0, 1'b0, 0,  16'h0000, 1'b1, 27, 1'b1, 1'b1, 1'b0, 27);

    for (int r = 0; r < NUM_TESTS; r++) begin
      run_row(r);
    end

    $display("%0d tests, %0d passed, %0d failed, %0d errors",
             NUM_TESTS, pass_count, fail_count, err_count);
    if (fail_count == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== tb_mem_model.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// behavioral 16-bit memory for the self-test testbench
// optional random stalls, a stuck-bit word and a hung word
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns
`include "memtest_defs.svh"

module tb_mem_model (
  input  logic                   clk,
  input  logic                   clear,
  input  logic                   stall_en,
  input  logic                   fault_en,
  input  logic [`MT_ADDR_W-1:0]  fault_addr,
  input  logic [`MT_BEAT_W-1:0]  fault_mask,
  input  logic                   hang_en,
  input  logic [`MT_ADDR_W-1:0]  hang_addr,
  input  logic                   mem_en,
  input  logic                   mem_we,
  input  logic [`MT_ADDR_W+1:0]  mem_addr,
  input  logic [`MT_BEAT_W-1:0]  mem_wdata,
  output logic                   mem_ready,
  output logic [`MT_BEAT_W-1:0]  mem_rdata
);

  localparam int DEPTH = 1 << (`MT_ADDR_W + 2);

  logic [`MT_BEAT_W-1:0] ram [0:DEPTH-1];
  integer                seed;
  logic                  accept;
  logic                  ready_next;
  logic [`MT_BEAT_W-1:0] rd_next;

  initial begin
    seed      = 62;
    mem_ready = 1'b0;
    mem_rdata = '0;
  end

  always @(posedge clk) begin
    accept  = mem_en & mem_ready;
    rd_next = mem_rdata;
    if (clear) begin
      // high byte never matches a pattern beat
      for (int i = 0; i < DEPTH; i++) begin
        ram[i] = {8'hEE, 8'(i)};
      end
    end else if (accept && mem_we) begin
      ram[mem_addr] = mem_wdata;
    end else if (accept) begin
      rd_next = ram[mem_addr];
      // masked bits read back stuck high
      if (fault_en && mem_addr[`MT_ADDR_W+1:2] == fault_addr) begin
        rd_next = rd_next | fault_mask;
      end
    end
    ready_next = 1'b1;
    if (stall_en && ($random(seed) & 3) == 0) begin
      ready_next = 1'b0;
    end
    #10;
    mem_rdata = rd_next;
    mem_ready = ready_next;
    if (hang_en && mem_addr[`MT_ADDR_W+1:2] == hang_addr) begin
      mem_ready = 1'b0;
    end
  end

endmodule

// ==== memtest_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// memory self-test top: sequencer, two-port controller and lamps
// attach the external 16-bit memory to the mem_* ports
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns
`include "memtest_defs.svh"

module memtest_top (
  input  logic                       clk,
  input  logic                       reset,
  output logic                       mem_en,
  output logic                       mem_we,
  output logic [`MT_ADDR_W+1:0]      mem_addr,
  output logic [`MT_BEAT_W-1:0]      mem_wdata,
  input  logic                       mem_ready,
  input  logic [`MT_BEAT_W-1:0]      mem_rdata,
  output memtest_pkg::test_status_t  status,
  output logic [6:0]                 ssl
);

  import memtest_pkg::*;

  mem_req_t  inst_req;
  mem_req_t  data_req;
  ram_word_u inst_rdata;
  ram_word_u data_rdata;
  logic      inst_ack;
  logic      inst_timeout;
  logic      data_ack;
  logic      data_timeout;

  ram_test ram_test_1 (
    .clk          (clk),
    .reset        (reset),
    .inst_req     (inst_req),
    .data_req     (data_req),
    .inst_rdata   (inst_rdata),
    .data_rdata   (data_rdata),
    .inst_ack     (inst_ack),
    .inst_timeout (inst_timeout),
    .data_ack     (data_ack),
    .data_timeout (data_timeout),
    .status       (status)
  );

  ram_ctrl ram_ctrl_1 (
    .clk          (clk),
    .reset        (reset),
    .inst_req     (inst_req),
    .data_req     (data_req),
    .inst_rdata   (inst_rdata),
    .data_rdata   (data_rdata),
    .inst_ack     (inst_ack),
    .inst_timeout (inst_timeout),
    .data_ack     (data_ack),
    .data_timeout (data_timeout),
    .mem_en       (mem_en),
    .mem_we       (mem_we),
    .mem_addr     (mem_addr),
    .mem_wdata    (mem_wdata),
    .mem_ready    (mem_ready),
    .mem_rdata    (mem_rdata)
  );

  status_display status_display_1 (
    .clk    (clk),
    .reset  (reset),
    .status (status),
    .ssl    (ssl)
  );

endmodule

// ==== status_display.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// status lamps: heartbeat blink plus the test state flags
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns
`include "memtest_defs.svh"

module status_display (
  input  logic                       clk,
  input  logic                       reset,
  input  memtest_pkg::test_status_t  status,
  output logic [6:0]                 ssl
);

  logic [`MT_HEARTBEAT_BIT:0] heartbeat;

  always_ff @(posedge clk) begin
    if (reset) begin
      heartbeat <= '0;
    end else begin
      heartbeat <= heartbeat + 1'b1;
    end
  end

  assign ssl[0] = heartbeat[`MT_HEARTBEAT_BIT];
  assign ssl[1] = status.running;
  // lamp 2 follows the reset line itself
  assign ssl[2] = reset;
  assign ssl[3] = status.timeout_seen;
  assign ssl[4] = status.ended;
  assign ssl[5] = status.error;
  assign ssl[6] = status.mismatch_seen;

endmodule

// ==== ram_ctrl.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// two-port memory controller: arbitrates the instruction and
// data ports and moves each word as four beats on the memory bus
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns
`include "memtest_defs.svh"

module ram_ctrl (
  input  logic                    clk,
  input  logic                    reset,
  input  memtest_pkg::mem_req_t   inst_req,
  input  memtest_pkg::mem_req_t   data_req,
  output memtest_pkg::ram_word_u  inst_rdata,
  output memtest_pkg::ram_word_u  data_rdata,
  output logic                    inst_ack,
  output logic                    inst_timeout,
  output logic                    data_ack,
  output logic                    data_timeout,
  output logic                    mem_en,
  output logic                    mem_we,
  output logic [`MT_ADDR_W+1:0]   mem_addr,
  output logic [`MT_BEAT_W-1:0]   mem_wdata,
  input  logic                    mem_ready,
  input  logic [`MT_BEAT_W-1:0]   mem_rdata
);

  import memtest_pkg::*;

  localparam int TMO_W = $clog2(`MT_TIMEOUT + 1);

  localparam logic [1:0] S_IDLE    = 2'd0;
  localparam logic [1:0] S_BEAT    = 2'd1;
  localparam logic [1:0] S_LAST_RD = 2'd2;
  localparam logic [1:0] S_DONE    = 2'd3;

  logic [1:0]            state;
  logic [1:0]            beat_idx;
  logic [TMO_W-1:0]      wait_cnt;

  // latched request of the granted port
  logic                  grant_data;
  logic                  cur_we;
  logic [`MT_ADDR_W-1:0] cur_addr;
  ram_word_u             cur_din;

  // read return, one cycle behind the accepted beat
  logic                  rd_pend;
  logic [1:0]            rd_idx;
  ram_word_u             rbuf;

  mem_req_t              req_sel;
  logic                  accept;

  // data port wins a tie
  assign req_sel = data_req.stb ? data_req : inst_req;

  assign mem_en    = (state == S_BEAT);
  assign mem_we    = mem_en & cur_we;
  assign mem_addr  = {cur_addr, beat_idx};
  assign mem_wdata = cur_din.beat[beat_idx];
  assign accept    = mem_en & mem_ready;

  always_ff @(posedge clk) begin
    if (reset) begin
      state        <= S_IDLE;
      beat_idx     <= '0;
      wait_cnt     <= '0;
      inst_ack     <= 1'b0;
      inst_timeout <= 1'b0;
      data_ack     <= 1'b0;
      data_timeout <= 1'b0;
    end else begin
      inst_ack     <= 1'b0;
      inst_timeout <= 1'b0;
      data_ack     <= 1'b0;
      data_timeout <= 1'b0;

      case (state)
        S_IDLE: begin
          if (req_sel.stb) begin
            beat_idx <= '0;
            wait_cnt <= '0;
            state    <= S_BEAT;
          end
        end

        S_BEAT: begin
          if (mem_ready) begin
            wait_cnt <= '0;
            beat_idx <= beat_idx + 1'b1;
            if (beat_idx == 2'd3) begin
              if (cur_we) begin
                inst_ack <= ~grant_data;
                data_ack <= grant_data;
                state    <= S_DONE;
              end else begin
                state <= S_LAST_RD;
              end
            end
          end else if (wait_cnt == TMO_W'(`MT_TIMEOUT - 1)) begin
            // beat stalled too long, give up on the whole word
            inst_timeout <= ~grant_data;
            data_timeout <= grant_data;
            state        <= S_DONE;
          end else begin
            wait_cnt <= wait_cnt + 1'b1;
          end
        end

        S_LAST_RD: begin
          // last beat lands in rbuf on this edge
          inst_ack <= ~grant_data;
          data_ack <= grant_data;
          state    <= S_DONE;
        end

        S_DONE: begin
          // stb is still up during the ack cycle, skip it
          state <= S_IDLE;
        end

        default: begin
          state <= S_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == S_IDLE && req_sel.stb) begin
      grant_data <= data_req.stb;
      cur_we     <= req_sel.we;
      cur_addr   <= req_sel.addr;
      cur_din    <= req_sel.din;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      rd_pend <= 1'b0;
    end else begin
      rd_pend <= accept & ~cur_we;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      rd_idx <= beat_idx;
    end
    if (rd_pend) begin
      rbuf.beat[rd_idx] <= mem_rdata;
    end
  end

  // one access at a time, so both ports share the buffer
  assign inst_rdata = rbuf;
  assign data_rdata = rbuf;

endmodule

// ==== ram_test.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// memory test sequencer: fills every word with its pattern,
// then reads all words back and reports the first failure
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ns
`include "memtest_defs.svh"

module ram_test (
  input  logic                       clk,
  input  logic                       reset,
  output memtest_pkg::mem_req_t      inst_req,
  output memtest_pkg::mem_req_t      data_req,
  input  memtest_pkg::ram_word_u     inst_rdata,
  input  memtest_pkg::ram_word_u     data_rdata,
  input  logic                       inst_ack,
  input  logic                       inst_timeout,
  input  logic                       data_ack,
  input  logic                       data_timeout,
  output memtest_pkg::test_status_t  status
);

  import memtest_pkg::*;

  localparam logic [1:0] T_ISSUE = 2'd0;
  localparam logic [1:0] T_WAIT  = 2'd1;
  localparam logic [1:0] T_END   = 2'd2;

  logic [1:0]            state;
  logic                  phase_check;
  logic [`MT_ADDR_W-1:0] addr;

  logic                  use_inst;
  logic                  done;
  logic                  tmo;
  logic                  bad_read;
  logic                  fail;
  logic                  last_addr;
  ram_word_u             rdata;
  ram_word_u             expect_w;

  // even words come back over the instruction port in the check phase
  assign use_inst = phase_check & ~addr[0];

  assign done  = use_inst ? (inst_ack | inst_timeout) : (data_ack | data_timeout);
  assign tmo   = use_inst ? inst_timeout : data_timeout;
  assign rdata = use_inst ? inst_rdata : data_rdata;

  assign expect_w  = pattern_of(addr);
  assign last_addr = &addr;

  // read data is meaningless after a timeout
  assign bad_read = phase_check & ~tmo & (rdata.word != expect_w.word);
  assign fail     = tmo | bad_read;

  always_ff @(posedge clk) begin
    if (reset) begin
      state        <= T_ISSUE;
      phase_check  <= 1'b0;
      addr         <= '0;
      inst_req.stb <= 1'b0;
      data_req.stb <= 1'b0;
      status       <= '0;
    end else begin
      case (state)
        T_ISSUE: begin
          // first pass through here also starts the run
          status.running <= 1'b1;

          inst_req.we   <= 1'b0;
          inst_req.addr <= addr;
          inst_req.din  <= expect_w;
          data_req.we   <= ~phase_check;
          data_req.addr <= addr;
          data_req.din  <= expect_w;

          if (use_inst) begin
            inst_req.stb <= 1'b1;
          end else begin
            data_req.stb <= 1'b1;
          end
          state <= T_WAIT;
        end

        T_WAIT: begin
          if (done) begin
            inst_req.stb <= 1'b0;
            data_req.stb <= 1'b0;

            if (fail) begin
              status.error <= 1'b1;
              if (tmo) begin
                status.timeout_seen <= 1'b1;
              end
              if (bad_read) begin
                status.mismatch_seen <= 1'b1;
              end
              // keep only the first failing word
              if (!status.error) begin
                status.fail_addr <= addr;
              end
            end

            addr <= addr + 1'b1;
            if (last_addr) begin
              if (phase_check) begin
                status.running <= 1'b0;
                status.ended   <= 1'b1;
                state          <= T_END;
              end else begin
                phase_check <= 1'b1;
                state       <= T_ISSUE;
              end
            end else begin
              state <= T_ISSUE;
            end
          end
        end

        T_END: begin
          // parked until the next reset
          state <= T_END;
        end

        default: begin
          state <= T_ISSUE;
        end
      endcase
    end
  end

endmodule

// ==== memtest_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// types shared by the test sequencer, controller and display
// plus the address-derived pattern rule
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "memtest_defs.svh"

package memtest_pkg;

  // one 64-bit word, seen whole or as four bus beats
  typedef union packed {
    logic [4*`MT_BEAT_W-1:0]     word;
    logic [3:0][`MT_BEAT_W-1:0]  beat;
  } ram_word_u;

  // request from the sequencer, stb held until ack or timeout
  typedef struct packed {
    logic                   stb;
    logic                   we;
    logic [`MT_ADDR_W-1:0]  addr;
    ram_word_u              din;
  } mem_req_t;

  typedef struct packed {
    logic                   running;
    logic                   ended;
    logic                   error;
    logic                   timeout_seen;
    logic                   mismatch_seen;
    logic [`MT_ADDR_W-1:0]  fail_addr;
  } test_status_t;

  // beat i = {addr, i} xor A5C3
  function automatic ram_word_u pattern_of(input logic [`MT_ADDR_W-1:0] addr);
    ram_word_u             w;
    logic [`MT_BEAT_W-1:0] b;
    for (int i = 0; i < 4; i++) begin
      b = '0;
      b[`MT_ADDR_W+1:0] = {addr, 2'(i)};
      w.beat[i] = b ^ 16'hA5C3;
    end
    return w;
  endfunction

endpackage

// ==== memtest_defs.svh ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// sizes and limits for the memory self-test
// include wherever a width, the timeout or the heartbeat bit is needed
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef MEMTEST_DEFS_SVH
`define MEMTEST_DEFS_SVH

// word address, 64 words
`define MT_ADDR_W 6

// external memory bus width, four beats per word
`define MT_BEAT_W 16

// stalled cycles allowed on one beat
`define MT_TIMEOUT 32

// small so the lamp visibly blinks in simulation
`define MT_HEARTBEAT_BIT 4

`endif
